/* build.f */
rtl/rv32_pkg.sv
rtl/profiler_pkg.sv
rtl/instr_classifier.sv
rtl/load_scoreboard.sv
rtl/stall_attributor.sv
rtl/event_counter_bank.sv
rtl/core_profiler.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_core_profiler.sv

/* rtl/core_profiler.sv */
`default_nettype none

module core_profiler (
  input logic clk_i,
  input logic reset_i,
  input profiler_pkg::exe_stage_s exe_i,
  input profiler_pkg::stall_s stall_i,
  input rv32_pkg::instr_t id_instr_i,
  input profiler_pkg::wb_clear_s wb_clear_i,
  input logic [profiler_pkg::EVENT_SEL_WIDTH-1:0] stat_sel_i,
  output logic [profiler_pkg::COUNTER_WIDTH-1:0] stat_o
);

  import profiler_pkg::*;

  event_vec_t retire_events;
  event_vec_t stall_events;
  event_vec_t events;
  load_retire_s load_retire;

  instr_classifier classifier_i (
    .exe_i(exe_i),
    .pipe_stall_i(stall_i.stall),
    .events_o(retire_events),
    .load_retire_o(load_retire)
  );

  stall_attributor attributor_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .stall_i(stall_i),
    .id_instr_i(id_instr_i),
    .load_retire_i(load_retire),
    .wb_clear_i(wb_clear_i),
    .events_o(stall_events)
  );

  assign events = retire_events | stall_events; // disjoint bits

  event_counter_bank counters_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .events_i(events),
    .sel_i(stat_sel_i),
    .count_o(stat_o)
  );

endmodule

`default_nettype wire

/* rtl/event_counter_bank.sv */
`default_nettype none

module event_counter_bank (
  input logic clk_i,
  input logic reset_i,
  input profiler_pkg::event_vec_t events_i,
  input logic [profiler_pkg::EVENT_SEL_WIDTH-1:0] sel_i,
  output logic [profiler_pkg::COUNTER_WIDTH-1:0] count_o
);

  import profiler_pkg::*;

  logic [NUM_EVENTS-1:0][COUNTER_WIDTH-1:0] count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end
    else begin
      for (int i = 0; i < NUM_EVENTS; i++) begin
        if (events_i[i]) begin
          count_r[i] <= count_r[i] + COUNTER_WIDTH'(1); // wraps
        end
      end
    end
  end

  assign count_o = count_r[sel_i];

endmodule

`default_nettype wire

/* rtl/instr_classifier.sv */
`default_nettype none

module instr_classifier (
  input profiler_pkg::exe_stage_s exe_i,
  input logic pipe_stall_i,
  output profiler_pkg::event_vec_t events_o,
  output profiler_pkg::load_retire_s load_retire_o
);

  import rv32_pkg::*;
  import profiler_pkg::*;

  logic retire;
  logic [6:0] opcode;
  logic [6:0] funct7;
  logic load_local;

  assign retire = ~pipe_stall_i & (exe_i.instr != '0); // zero word is a bubble
  assign opcode = get_opcode(exe_i.instr);
  assign funct7 = get_funct7(exe_i.instr);
  assign load_local = is_local_addr(exe_i.mem_addr);

  always_comb begin
    events_o = '0;
    load_retire_o = '0;

    if (retire) begin
      events_o[EV_INSTR] = 1'b1;

      case (opcode)
        OPC_OP: begin
          if (funct7 == FUNCT7_MULDIV) begin
            events_o[EV_MULDIV] = 1'b1;
          end
          else begin
            events_o[EV_ALU] = 1'b1;
          end
        end
        OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
          events_o[EV_ALU] = 1'b1;
        end
        OPC_BRANCH: begin
          events_o[EV_BRANCH] = 1'b1;
          events_o[EV_BRANCH_MISS] = exe_i.branch_miss;
        end
        OPC_JAL: begin
          events_o[EV_JAL] = 1'b1;
        end
        OPC_JALR: begin
          events_o[EV_JALR] = 1'b1;
          events_o[EV_JALR_MISS] = exe_i.jalr_miss;
        end
        OPC_LOAD: begin
          events_o[EV_LOAD_LOCAL] = load_local;
          events_o[EV_LOAD_REMOTE] = ~load_local;
          // record for the scoreboard
          load_retire_o.v = 1'b1;
          load_retire_o.rd = get_rd(exe_i.instr);
          load_retire_o.remote = ~load_local;
        end
        OPC_STORE: begin
          events_o[EV_STORE] = 1'b1;
        end
        default: begin
          // only counted as an instruction
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/load_scoreboard.sv */
`default_nettype none

module load_scoreboard (
  input logic clk_i,
  input logic reset_i,
  input profiler_pkg::load_retire_s score_i,
  input profiler_pkg::wb_clear_s clear_i,
  input rv32_pkg::reg_addr_t rs1_i,
  input rv32_pkg::reg_addr_t rs2_i,
  output logic [1:0] rs1_pend_o,
  output logic [1:0] rs2_pend_o
);

  import rv32_pkg::*;

  // entry bit 1 remote load, bit 0 local load
  logic [2**REG_ADDR_WIDTH-1:0][1:0] sb_r;

  logic score_en;

  assign score_en = score_i.v & (score_i.rd != '0); // x0 never waits

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sb_r <= '0;
    end
    else begin
      if (clear_i.v) begin
        sb_r[clear_i.rd] <= 2'b00;
      end
      // later assignment, so a score beats a clear on the same rd
      if (score_en) begin
        sb_r[score_i.rd] <= {score_i.remote, ~score_i.remote};
      end
    end
  end

  assign rs1_pend_o = sb_r[rs1_i];
  assign rs2_pend_o = sb_r[rs2_i];

endmodule

`default_nettype wire

/* rtl/profiler_pkg.sv */
`default_nettype none

package profiler_pkg;

  localparam int DATA_WIDTH = 32;
  localparam int COUNTER_WIDTH = 32;
  localparam int DMEM_ADDR_WIDTH = 10; // word address bits of local dmem
  localparam int NUM_EVENTS = 16;
  localparam int EVENT_SEL_WIDTH = 4;

  localparam int EV_CYCLE = 0;
  localparam int EV_INSTR = 1;
  localparam int EV_ALU = 2;
  localparam int EV_MULDIV = 3;
  localparam int EV_LOAD_LOCAL = 4;
  localparam int EV_LOAD_REMOTE = 5;
  localparam int EV_STORE = 6;
  localparam int EV_BRANCH = 7;
  localparam int EV_BRANCH_MISS = 8;
  localparam int EV_JAL = 9;
  localparam int EV_JALR = 10;
  localparam int EV_JALR_MISS = 11;
  localparam int EV_STALL = 12;
  localparam int EV_STALL_DEPEND = 13;
  localparam int EV_STALL_DEPEND_LOCAL = 14;
  localparam int EV_STALL_DEPEND_REMOTE = 15;

  typedef logic [NUM_EVENTS-1:0] event_vec_t;

  typedef struct packed {
    rv32_pkg::instr_t instr;
    logic [DATA_WIDTH-1:0] mem_addr;
    logic branch_miss;
    logic jalr_miss;
  } exe_stage_s;

  typedef struct packed {
    logic v;
    rv32_pkg::reg_addr_t rd;
    logic remote;
  } load_retire_s;

  typedef struct packed {
    logic v;
    rv32_pkg::reg_addr_t rd;
  } wb_clear_s;

  typedef struct packed {
    logic stall;
    logic depend;
  } stall_s;

  // local dmem is mapped at one window above the low page
  function automatic logic is_local_addr(logic [DATA_WIDTH-1:0] addr);
    return addr[DMEM_ADDR_WIDTH+2] & (addr[DATA_WIDTH-1:DMEM_ADDR_WIDTH+3] == '0);
  endfunction

endpackage

`default_nettype wire

/* rtl/rv32_pkg.sv */
`default_nettype none

package rv32_pkg;

  localparam int REG_ADDR_WIDTH = 5;
  localparam int INSTR_WIDTH = 32;

  typedef logic [INSTR_WIDTH-1:0] instr_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  // R-type layout, rd/rs1/rs2 sit at the same spots in every format
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t rs2;
    reg_addr_t rs1;
    logic [2:0] funct3;
    reg_addr_t rd;
    logic [6:0] opcode;
  } instr_fields_s;

  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP = 7'b0110011;

  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // M extension within OPC_OP

  function automatic logic [6:0] get_opcode(instr_t instr);
    instr_fields_s f;
    f = instr;
    return f.opcode;
  endfunction

  function automatic logic [6:0] get_funct7(instr_t instr);
    instr_fields_s f;
    f = instr;
    return f.funct7;
  endfunction

  function automatic reg_addr_t get_rd(instr_t instr);
    instr_fields_s f;
    f = instr;
    return f.rd;
  endfunction

  function automatic reg_addr_t get_rs1(instr_t instr);
    instr_fields_s f;
    f = instr;
    return f.rs1;
  endfunction

  function automatic reg_addr_t get_rs2(instr_t instr);
    instr_fields_s f;
    f = instr;
    return f.rs2;
  endfunction

  // u-type and jal carry no rs1
  function automatic logic reads_rs1(instr_t instr);
    logic [6:0] opc;
    opc = get_opcode(instr);
    return !(opc == OPC_LUI || opc == OPC_AUIPC || opc == OPC_JAL);
  endfunction

  function automatic logic reads_rs2(instr_t instr);
    logic [6:0] opc;
    opc = get_opcode(instr);
    return (opc == OPC_OP || opc == OPC_BRANCH || opc == OPC_STORE);
  endfunction

endpackage

`default_nettype wire

/* rtl/stall_attributor.sv */
`default_nettype none

module stall_attributor (
  input logic clk_i,
  input logic reset_i,
  input profiler_pkg::stall_s stall_i,
  input rv32_pkg::instr_t id_instr_i,
  input profiler_pkg::load_retire_s load_retire_i,
  input profiler_pkg::wb_clear_s wb_clear_i,
  output profiler_pkg::event_vec_t events_o
);

  import rv32_pkg::*;
  import profiler_pkg::*;

  logic [1:0] rs1_pend;
  logic [1:0] rs2_pend;
  logic [1:0] rs1_hit;
  logic [1:0] rs2_hit;
  logic depend_stall;

  load_scoreboard sb_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .score_i(load_retire_i),
    .clear_i(wb_clear_i),
    .rs1_i(get_rs1(id_instr_i)),
    .rs2_i(get_rs2(id_instr_i)),
    .rs1_pend_o(rs1_pend),
    .rs2_pend_o(rs2_pend)
  );

  // ignore operand fields the decode instr does not use
  assign rs1_hit = reads_rs1(id_instr_i) ? rs1_pend : 2'b00;
  assign rs2_hit = reads_rs2(id_instr_i) ? rs2_pend : 2'b00;

  assign depend_stall = stall_i.depend & ~stall_i.stall; // full stall takes priority

  always_comb begin
    events_o = '0;
    events_o[EV_CYCLE] = 1'b1;
    events_o[EV_STALL] = stall_i.stall;
    events_o[EV_STALL_DEPEND] = depend_stall;
    events_o[EV_STALL_DEPEND_LOCAL] = depend_stall & (rs1_hit[0] | rs2_hit[0]);
    events_o[EV_STALL_DEPEND_REMOTE] = depend_stall & (rs1_hit[1] | rs2_hit[1]);
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the profiler testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_core_profiler -f build.f -o sim_core_profiler
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_core_profiler > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" sim.log; then
  exit 0
fi
exit 1

/* test/tb_checker.sv */
`default_nettype none

module tb_checker (
  input logic clk_i,
  input logic reset_i,
  input profiler_pkg::exe_stage_s exe_i,
  input profiler_pkg::stall_s stall_i,
  input rv32_pkg::instr_t id_instr_i,
  input profiler_pkg::wb_clear_s wb_clear_i,
  input logic [profiler_pkg::EVENT_SEL_WIDTH-1:0] stat_sel_i,
  input logic [profiler_pkg::COUNTER_WIDTH-1:0] stat_i,
  input logic check_en_i,
  output int error_count_o,
  output int check_count_o
);

  import rv32_pkg::*;
  import profiler_pkg::*;

  logic [COUNTER_WIDTH-1:0] exp_count [NUM_EVENTS];
  logic [1:0] pend [32]; // bit 1 remote, bit 0 local

  function automatic string event_name(int idx);
    case (idx)
      EV_CYCLE: return "cycle";
      EV_INSTR: return "instr";
      EV_ALU: return "alu";
      EV_MULDIV: return "muldiv";
      EV_LOAD_LOCAL: return "load_local";
      EV_LOAD_REMOTE: return "load_remote";
      EV_STORE: return "store";
      EV_BRANCH: return "branch";
      EV_BRANCH_MISS: return "branch_miss";
      EV_JAL: return "jal";
      EV_JALR: return "jalr";
      EV_JALR_MISS: return "jalr_miss";
      EV_STALL: return "stall";
      EV_STALL_DEPEND: return "stall_depend";
      EV_STALL_DEPEND_LOCAL: return "stall_depend_local";
      default: return "stall_depend_remote";
    endcase
  endfunction

  task automatic incr(int idx);
    exp_count[idx] = exp_count[idx] + 1;
  endtask

  // lookups see the scoreboard before this edge
  task automatic attribute_depend();
    logic [6:0] opc;
    logic [1:0] hit;
    opc = id_instr_i[6:0];
    hit = 2'b00;
    incr(EV_STALL_DEPEND);
    if (opc != OPC_LUI && opc != OPC_AUIPC && opc != OPC_JAL) begin
      hit = hit | pend[id_instr_i[19:15]];
    end
    if (opc == OPC_OP || opc == OPC_BRANCH || opc == OPC_STORE) begin
      hit = hit | pend[id_instr_i[24:20]];
    end
    if (hit[0]) begin
      incr(EV_STALL_DEPEND_LOCAL);
    end
    if (hit[1]) begin
      incr(EV_STALL_DEPEND_REMOTE);
    end
  endtask

  task automatic count_retire();
    logic [6:0] opc;
    logic in_window;
    opc = exe_i.instr[6:0];
    in_window = exe_i.mem_addr[DMEM_ADDR_WIDTH+2]
                && (exe_i.mem_addr[31:DMEM_ADDR_WIDTH+3] == '0);
    incr(EV_INSTR);
    case (opc)
      OPC_OP: begin
        incr((exe_i.instr[31:25] == FUNCT7_MULDIV) ? EV_MULDIV : EV_ALU);
      end
      OPC_OP_IMM, OPC_LUI, OPC_AUIPC: begin
        incr(EV_ALU);
      end
      OPC_BRANCH: begin
        incr(EV_BRANCH);
        if (exe_i.branch_miss) begin
          incr(EV_BRANCH_MISS);
        end
      end
      OPC_JAL: begin
        incr(EV_JAL);
      end
      OPC_JALR: begin
        incr(EV_JALR);
        if (exe_i.jalr_miss) begin
          incr(EV_JALR_MISS);
        end
      end
      OPC_LOAD: begin
        incr(in_window ? EV_LOAD_LOCAL : EV_LOAD_REMOTE);
        if (exe_i.instr[11:7] != 5'd0) begin
          pend[exe_i.instr[11:7]] = in_window ? 2'b01 : 2'b10; // after the clear
        end
      end
      OPC_STORE: begin
        incr(EV_STORE);
      end
      default: begin
      end
    endcase
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_EVENTS; i++) begin
        exp_count[i] = '0;
      end
      for (int i = 0; i < 32; i++) begin
        pend[i] = 2'b00;
      end
      error_count_o = 0;
      check_count_o = 0;
    end
    else begin
      if (check_en_i) begin
        check_count_o = check_count_o + 1;
        if (stat_i !== exp_count[stat_sel_i]) begin
          error_count_o = error_count_o + 1;
          $display("Error %s expected %0d actual %0d",
                   event_name(int'(stat_sel_i)), exp_count[stat_sel_i], stat_i);
        end
      end
      incr(EV_CYCLE);
      if (stall_i.stall) begin
        incr(EV_STALL);
      end
      else if (stall_i.depend) begin
        attribute_depend();
      end
      if (wb_clear_i.v) begin
        pend[wb_clear_i.rd] = 2'b00;
      end
      if (!stall_i.stall && exe_i.instr != '0) begin
        count_retire();
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o; // period 4
  end

  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

/* test/tb_core_profiler.sv */
`default_nettype none

module tb_core_profiler;

  import rv32_pkg::*;
  import profiler_pkg::*;

  typedef struct packed {
    instr_t exe_instr;
    logic [DATA_WIDTH-1:0] mem_addr;
    logic branch_miss;
    logic jalr_miss;
    logic stall;
    logic depend;
    instr_t id_instr;
    logic wb_v;
    reg_addr_t wb_rd;
  } stim_row_s;

  logic clk;
  logic reset;
  exe_stage_s exe;
  stall_s stall;
  instr_t id_instr;
  wb_clear_s wb_clear;
  logic [EVENT_SEL_WIDTH-1:0] stat_sel;
  logic [COUNTER_WIDTH-1:0] stat;
  logic check_en;
  int error_count;
  int check_count;
  int cycle_count = 0;
  int cycle_limit = 1000;
  string cur_row = "reset";
  string row_name [$];
  stim_row_s rows [$];

  tb_clock clock_i (.clk_o(clk), .reset_o(reset));

  core_profiler dut_i (
    .clk_i(clk),
    .reset_i(reset),
    .exe_i(exe),
    .stall_i(stall),
    .id_instr_i(id_instr),
    .wb_clear_i(wb_clear),
    .stat_sel_i(stat_sel),
    .stat_o(stat)
  );

  tb_checker checker_i (
    .clk_i(clk),
    .reset_i(reset),
    .exe_i(exe),
    .stall_i(stall),
    .id_instr_i(id_instr),
    .wb_clear_i(wb_clear),
    .stat_sel_i(stat_sel),
    .stat_i(stat),
    .check_en_i(check_en),
    .error_count_o(error_count),
    .check_count_o(check_count)
  );

  task automatic add_row(string name, instr_t ex, logic [31:0] addr, logic bmiss,
                         logic jmiss, logic st, logic dep, instr_t id, logic wb_v,
                         reg_addr_t wb_rd);
    stim_row_s r;
    r.exe_instr = ex;
    r.mem_addr = addr;
    r.branch_miss = bmiss;
    r.jalr_miss = jmiss;
    r.stall = st;
    r.depend = dep;
    r.id_instr = id;
    r.wb_v = wb_v;
    r.wb_rd = wb_rd;
    row_name.push_back(name);
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row("add", 32'h002081B3, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("addi", 32'h00100293, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("mul", 32'h02208333, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("div", 32'h0220C3B3, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("lui", 32'h12345437, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("jal", 32'h008000EF, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("jalr_hit", 32'h00008067, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("jalr_miss", 32'h00008067, 32'h0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("beq_hit", 32'h00208463, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("beq_miss", 32'h00208463, 32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("sw", 32'h0020A223, 32'h1008, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("bubble", 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("stalled_add", 32'h002081B3, 32'h0, 1'b0, 1'b0, 1'b1, 1'b0, 32'h0, 1'b0, 5'd0);
    // x10 local, x11 and x12 remote
    add_row("lw_local", 32'h00002503, 32'h1004, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("lw_rem_hi", 32'h00002583, 32'h80001000, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("lw_rem_lo", 32'h00002603, 32'h4, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("dep_remote", 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h000586B3, 1'b0, 5'd0);
    add_row("dep_local", 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h00A00733, 1'b0, 5'd0);
    add_row("dep_both", 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h00A587B3, 1'b0, 5'd0);
    add_row("dep_lui", 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h000586B7, 1'b0, 5'd0);
    add_row("stall_dep", 32'h0, 32'h0, 1'b0, 1'b0, 1'b1, 1'b1, 32'h000586B3, 1'b0, 5'd0);
    add_row("clear_x11", 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 5'd11);
    add_row("dep_cleared", 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h000586B3, 1'b0, 5'd0);
    // score of x12 beats its clear in the same cycle
    add_row("score_clear", 32'h00002603, 32'h1010, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b1, 5'd12);
    add_row("dep_x12", 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h00060833, 1'b0, 5'd0);
    add_row("lw_x0", 32'h00002003, 32'h4, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0, 5'd0);
    add_row("dep_x0", 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h000008B3, 1'b0, 5'd0);
  endtask

  task automatic apply_row(stim_row_s r);
    exe.instr = r.exe_instr;
    exe.mem_addr = r.mem_addr;
    exe.branch_miss = r.branch_miss;
    exe.jalr_miss = r.jalr_miss;
    stall.stall = r.stall;
    stall.depend = r.depend;
    id_instr = r.id_instr;
    wb_clear.v = r.wb_v;
    wb_clear.rd = r.wb_rd;
  endtask

  task automatic drive_idle();
    exe = '0;
    stall = '0;
    id_instr = '0;
    wb_clear = '0;
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("simulation timed out after %0d cycles in %s", cycle_count, cur_row);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    drive_idle();
    stat_sel = '0;
    check_en = 1'b0;
    build_table();
    cycle_limit = 3 + rows.size() + NUM_EVENTS + 20;
    wait (reset == 1'b0);
    foreach (rows[i]) begin
      @(negedge clk);
      apply_row(rows[i]);
      cur_row = row_name[i];
    end
    @(negedge clk);
    drive_idle();
    cur_row = "readout";
    for (int k = 0; k < NUM_EVENTS; k++) begin
      @(negedge clk);
      stat_sel = EVENT_SEL_WIDTH'(k);
      check_en = 1'b1;
    end
    @(negedge clk);
    check_en = 1'b0;
    $display("rows: %0d  checks: %0d  errors: %0d", rows.size(), check_count, error_count);
    if (error_count == 0 && check_count == NUM_EVENTS) begin
      $display("RESULT: PASS");
    end
    else begin
      if (check_count != NUM_EVENTS) begin
        $display("readout sweep compared %0d of %0d counters", check_count, NUM_EVENTS);
      end
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
